//--- common/pha_regs_pkg.sv
package pha_regs_pkg;

  // apb address and data widths.
  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;

  // register byte offsets.
  localparam logic [ADDR_W-1:0] REG_CTRL     = 12'h000;
  localparam logic [ADDR_W-1:0] REG_STATUS   = 12'h004;
  localparam logic [ADDR_W-1:0] REG_HOLDOFF  = 12'h008;
  localparam logic [ADDR_W-1:0] REG_MIN_CUT  = 12'h00C;
  localparam logic [ADDR_W-1:0] REG_MAX_CUT  = 12'h010;
  localparam logic [ADDR_W-1:0] REG_BASELINE = 12'h014;

  // bin k sits at BIN_BASE + 4*k.
  localparam logic [ADDR_W-1:0] BIN_BASE     = 12'h400;

  // control register bits.
  localparam int CTRL_FIXED_BIT = 0;
  localparam int CTRL_CLEAR_BIT = 1;

endpackage

//--- common/pha_data_pkg.sv
package pha_data_pkg;

  localparam int SAMPLE_W = 16;
  localparam int HOLD_W   = 16;
  localparam int COUNT_W  = 32;

  // samples and pulse heights share one width.
  typedef logic [SAMPLE_W-1:0] sample_t;

  typedef logic [COUNT_W-1:0] count_t;

endpackage

//--- analyzer/pha_peak_detector.sv
`timescale 1ns/1ns

module pha_peak_detector (
  input  logic                              aclk,
  input  logic                              aresetn,

  input  pha_data_pkg::sample_t             sample_data,
  input  logic                              sample_valid,
  output logic                              sample_ready,

  input  logic [pha_data_pkg::HOLD_W-1:0]   cfg_holdoff,
  input  pha_data_pkg::sample_t             cfg_min_cut,
  input  pha_data_pkg::sample_t             cfg_max_cut,
  input  pha_data_pkg::sample_t             cfg_baseline,
  input  logic                              cfg_fixed,

  output pha_data_pkg::sample_t             evt_height,
  output logic                              evt_valid,
  input  logic                              evt_ready
);

  pha_data_pkg::sample_t               smp_last;
  pha_data_pkg::sample_t               smp_prev;
  pha_data_pkg::sample_t               min_q;
  pha_data_pkg::sample_t               baseline;
  pha_data_pkg::sample_t               height;
  logic [pha_data_pkg::HOLD_W-1:0]     holdoff_cnt;
  logic                                rising_q;
  logic                                armed;
  logic                                accept;
  logic                                rising_now;
  logic                                in_holdoff;
  logic                                min_found;
  logic                                peak_found;
  logic                                pass_cuts;

  // stall input only while an event waits downstream.
  assign sample_ready = !(evt_valid && !evt_ready);
  assign accept       = sample_valid && sample_ready;

  assign rising_now = smp_prev < sample_data;
  assign in_holdoff = holdoff_cnt < cfg_holdoff;
  assign baseline   = cfg_fixed ? cfg_baseline : min_q;
  assign height     = smp_last - baseline;

  // falling to rising after hold-off marks the minimum.
  assign min_found  = accept && !in_holdoff && !rising_q && rising_now;

  // rising to not rising marks the peak.
  assign peak_found = accept && armed && rising_q && !rising_now;
  assign pass_cuts  = (height > cfg_min_cut) && (smp_last < cfg_max_cut);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      smp_last    <= '0;
      smp_prev    <= '0;
      min_q       <= '0;
      rising_q    <= 1'b0;
      armed       <= 1'b0;
      holdoff_cnt <= '0;
      evt_height  <= '0;
      evt_valid   <= 1'b0;
    end
    else
    begin
      if (accept)
      begin
        smp_last <= sample_data;
        smp_prev <= smp_last;
        rising_q <= rising_now;
      end

      if (peak_found)
        holdoff_cnt <= '0;
      else if (accept && in_holdoff)
        holdoff_cnt <= holdoff_cnt + 1'b1;

      if (min_found)
        min_q <= smp_prev;

      // any peak ends the search, cut or not.
      if (peak_found)
        armed <= 1'b0;
      else if (min_found)
        armed <= 1'b1;

      if (evt_valid && evt_ready)
        evt_valid <= 1'b0;
      if (peak_found && pass_cuts)
      begin
        evt_height <= height;
        evt_valid  <= 1'b1;
      end
    end
  end

  property p_evt_hold;
    @(posedge aclk) disable iff (!aresetn)
      evt_valid && !evt_ready |=> evt_valid && $stable(evt_height);
  endproperty

  a_evt_hold: assert property (p_evt_hold)
    else $error("event height changed under back-pressure");

endmodule

//--- src/pha_event_fifo.sv
`timescale 1ns/1ns

module pha_event_fifo #(
  parameter int DEPTH = 8
) (
  input  logic                  aclk,
  input  logic                  aresetn,

  input  pha_data_pkg::sample_t wr_data,
  input  logic                  wr_valid,
  output logic                  wr_ready,

  output pha_data_pkg::sample_t rd_data,
  output logic                  rd_valid,
  input  logic                  rd_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  pha_data_pkg::sample_t mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  wr_en;
  logic                  rd_en;

  assign wr_ready = count != CNT_W'(DEPTH);
  assign rd_valid = count != '0;
  assign rd_data  = mem[rd_ptr];
  assign wr_en    = wr_valid && wr_ready;
  assign rd_en    = rd_valid && rd_ready;

  always_ff @(posedge aclk)
  begin
    if (wr_en)
      mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (wr_en && !rd_en)
        count <= count + 1'b1;
      else if (rd_en && !wr_en)
        count <= count - 1'b1;
    end
  end

  a_count_range: assert property (@(posedge aclk) disable iff (!aresetn)
    count <= CNT_W'(DEPTH));

  // a full fifo keeps its oldest word until it is read.
  a_no_write_full: assert property (@(posedge aclk) disable iff (!aresetn)
    count == CNT_W'(DEPTH) && !rd_en |=> $stable(rd_data));

endmodule

//--- histogram/pha_histogram.sv
`timescale 1ns/1ns

module pha_histogram #(
  parameter int BIN_BITS = 8
) (
  input  logic                  aclk,
  input  logic                  aresetn,

  input  pha_data_pkg::sample_t hist_height,
  input  logic                  hist_valid,
  output logic                  hist_ready,

  input  logic                  clear_start,
  output logic                  clear_busy,

  input  logic [BIN_BITS-1:0]   bin_rd_addr,
  input  logic                  bin_rd_en,
  output pha_data_pkg::count_t  bin_rd_data,
  output logic                  bin_rd_done
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_READ  = 2'd1;
  localparam logic [1:0] ST_WRITE = 2'd2;
  localparam logic [1:0] ST_CLEAR = 2'd3;

  pha_data_pkg::count_t mem [2**BIN_BITS];
  pha_data_pkg::count_t ram_q;
  pha_data_pkg::count_t ram_wdata;
  logic [BIN_BITS-1:0]  ram_addr;
  logic                 ram_we;
  logic [1:0]           state;
  logic [BIN_BITS-1:0]  bin_idx;
  logic [BIN_BITS-1:0]  clr_addr;
  logic [BIN_BITS-1:0]  rd_addr_q;
  logic                 rd_pending;
  logic                 clr_pending;
  logic                 rd_req;
  logic                 rd_serve;

  assign rd_req     = bin_rd_en || rd_pending;
  assign rd_serve   = (state == ST_IDLE) && rd_req;
  assign clear_busy = (state == ST_CLEAR) || clr_pending;
  assign hist_ready = (state == ST_IDLE) && !rd_req && !clr_pending && !clear_start;
  assign bin_rd_data = ram_q;

  // single port, address picked by state.
  always_comb
  begin
    ram_we    = 1'b0;
    ram_wdata = '0;
    ram_addr  = bin_rd_en ? bin_rd_addr : rd_addr_q;
    case (state)
      ST_READ:  ram_addr = bin_idx;
      ST_WRITE:
      begin
        ram_addr  = bin_idx;
        ram_we    = 1'b1;
        ram_wdata = (ram_q == '1) ? ram_q : ram_q + 1'b1;
      end
      ST_CLEAR:
      begin
        ram_addr = clr_addr;
        ram_we   = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge aclk)
  begin
    if (ram_we)
      mem[ram_addr] <= ram_wdata;
    ram_q <= mem[ram_addr];
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state       <= ST_IDLE;
      bin_idx     <= '0;
      clr_addr    <= '0;
      rd_addr_q   <= '0;
      rd_pending  <= 1'b0;
      clr_pending <= 1'b0;
      bin_rd_done <= 1'b0;
    end
    else
    begin
      bin_rd_done <= rd_serve;
      if (bin_rd_en)
        rd_addr_q <= bin_rd_addr;
      rd_pending <= rd_req && !rd_serve;
      if (clear_start && state != ST_IDLE)
        clr_pending <= 1'b1;

      case (state)
        ST_IDLE:
        begin
          if (clear_start || clr_pending)
          begin
            clr_pending <= 1'b0;
            clr_addr    <= '0;
            state       <= ST_CLEAR;
          end
          else if (hist_valid && hist_ready)
          begin
            bin_idx <= hist_height[pha_data_pkg::SAMPLE_W-1 -: BIN_BITS];
            state   <= ST_READ;
          end
        end
        ST_READ:  state <= ST_WRITE;
        ST_WRITE: state <= ST_IDLE;
        default:
        begin
          clr_addr <= clr_addr + 1'b1;
          if (clr_addr == '1)
            state <= ST_IDLE;
        end
      endcase
    end
  end

  // the register block must hold off a second clear.
  a_clear_idle: assert property (@(posedge aclk) disable iff (!aresetn)
    clear_start |-> !clear_busy);

endmodule

//--- src/pha_apb_regs.sv
`timescale 1ns/1ns

module pha_apb_regs #(
  parameter int BIN_BITS = 8
) (
  input  logic                                aclk,
  input  logic                                aresetn,

  input  logic [pha_regs_pkg::ADDR_W-1:0]     paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [pha_regs_pkg::DATA_W-1:0]     pwdata,
  output logic [pha_regs_pkg::DATA_W-1:0]     prdata,
  output logic                                pready,
  output logic                                pslverr,

  output logic [pha_data_pkg::HOLD_W-1:0]     cfg_holdoff,
  output pha_data_pkg::sample_t               cfg_min_cut,
  output pha_data_pkg::sample_t               cfg_max_cut,
  output pha_data_pkg::sample_t               cfg_baseline,
  output logic                                cfg_fixed,

  output logic                                clear_start,
  input  logic                                clear_busy,

  output logic [BIN_BITS-1:0]                 bin_rd_addr,
  output logic                                bin_rd_en,
  input  pha_data_pkg::count_t                bin_rd_data,
  input  logic                                bin_rd_done
);

  localparam int BIN_END = int'(pha_regs_pkg::BIN_BASE) + (4 << BIN_BITS);

  logic [pha_regs_pkg::DATA_W-1:0] rd_word;
  logic                            access;
  logic                            is_bin;
  logic                            reg_hit;
  logic                            bin_access;
  logic                            rd_busy;

  assign access      = psel && penable;
  assign is_bin      = (paddr >= pha_regs_pkg::BIN_BASE) && (int'(paddr) < BIN_END);
  assign bin_access  = access && is_bin && !pwrite;
  assign bin_rd_addr = paddr[2 +: BIN_BITS];

  always_comb
  begin
    reg_hit = 1'b1;
    rd_word = '0;
    case (paddr)
      pha_regs_pkg::REG_CTRL:     rd_word[pha_regs_pkg::CTRL_FIXED_BIT] = cfg_fixed;
      pha_regs_pkg::REG_STATUS:   rd_word[0] = clear_busy;
      pha_regs_pkg::REG_HOLDOFF:  rd_word[pha_data_pkg::HOLD_W-1:0] = cfg_holdoff;
      pha_regs_pkg::REG_MIN_CUT:  rd_word[pha_data_pkg::SAMPLE_W-1:0] = cfg_min_cut;
      pha_regs_pkg::REG_MAX_CUT:  rd_word[pha_data_pkg::SAMPLE_W-1:0] = cfg_max_cut;
      pha_regs_pkg::REG_BASELINE: rd_word[pha_data_pkg::SAMPLE_W-1:0] = cfg_baseline;
      default:                    reg_hit = 1'b0;
    endcase
  end

  // bin reads stretch the access phase until data returns.
  assign pready  = bin_access ? bin_rd_done : 1'b1;
  assign pslverr = access && !(reg_hit || (is_bin && !pwrite));
  assign prdata  = is_bin ? bin_rd_data : rd_word;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      cfg_holdoff  <= '0;
      cfg_min_cut  <= '0;
      cfg_max_cut  <= '0;
      cfg_baseline <= '0;
      cfg_fixed    <= 1'b0;
      clear_start  <= 1'b0;
      bin_rd_en    <= 1'b0;
      rd_busy      <= 1'b0;
    end
    else
    begin
      clear_start <= 1'b0;
      bin_rd_en   <= 1'b0;
      if (access && pwrite && reg_hit)
      begin
        case (paddr)
          pha_regs_pkg::REG_CTRL:
          begin
            cfg_fixed   <= pwdata[pha_regs_pkg::CTRL_FIXED_BIT];
            clear_start <= pwdata[pha_regs_pkg::CTRL_CLEAR_BIT] && !clear_busy;
          end
          pha_regs_pkg::REG_HOLDOFF:  cfg_holdoff  <= pwdata[pha_data_pkg::HOLD_W-1:0];
          pha_regs_pkg::REG_MIN_CUT:  cfg_min_cut  <= pwdata[pha_data_pkg::SAMPLE_W-1:0];
          pha_regs_pkg::REG_MAX_CUT:  cfg_max_cut  <= pwdata[pha_data_pkg::SAMPLE_W-1:0];
          pha_regs_pkg::REG_BASELINE: cfg_baseline <= pwdata[pha_data_pkg::SAMPLE_W-1:0];
          default: ;
        endcase
      end

      // one request per bin read.
      if (bin_access && !rd_busy)
      begin
        bin_rd_en <= 1'b1;
        rd_busy   <= 1'b1;
      end
      else if (bin_rd_done)
        rd_busy <= 1'b0;
    end
  end

endmodule

//--- src/pha_top.sv
`timescale 1ns/1ns

module pha_top #(
  parameter int BIN_BITS   = 8,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                              aclk,
  input  logic                              aresetn,

  input  logic [pha_regs_pkg::ADDR_W-1:0]   paddr,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [pha_regs_pkg::DATA_W-1:0]   pwdata,
  output logic [pha_regs_pkg::DATA_W-1:0]   prdata,
  output logic                              pready,
  output logic                              pslverr,

  input  pha_data_pkg::sample_t             sample_data,
  input  logic                              sample_valid,
  output logic                              sample_ready
);

  logic [pha_data_pkg::HOLD_W-1:0] cfg_holdoff;
  pha_data_pkg::sample_t           cfg_min_cut;
  pha_data_pkg::sample_t           cfg_max_cut;
  pha_data_pkg::sample_t           cfg_baseline;
  logic                            cfg_fixed;
  pha_data_pkg::sample_t           evt_height;
  logic                            evt_valid;
  logic                            evt_ready;
  pha_data_pkg::sample_t           hist_height;
  logic                            hist_valid;
  logic                            hist_ready;
  logic                            clear_start;
  logic                            clear_busy;
  logic [BIN_BITS-1:0]             bin_rd_addr;
  logic                            bin_rd_en;
  pha_data_pkg::count_t            bin_rd_data;
  logic                            bin_rd_done;

  pha_apb_regs #(.BIN_BITS(BIN_BITS)) u_regs (
    .aclk, .aresetn,
    .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .cfg_holdoff, .cfg_min_cut, .cfg_max_cut, .cfg_baseline, .cfg_fixed,
    .clear_start, .clear_busy,
    .bin_rd_addr, .bin_rd_en, .bin_rd_data, .bin_rd_done
  );

  pha_peak_detector u_detector (
    .aclk, .aresetn,
    .sample_data, .sample_valid, .sample_ready,
    .cfg_holdoff, .cfg_min_cut, .cfg_max_cut, .cfg_baseline, .cfg_fixed,
    .evt_height, .evt_valid, .evt_ready
  );

  pha_event_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
    .aclk, .aresetn,
    .wr_data(evt_height), .wr_valid(evt_valid), .wr_ready(evt_ready),
    .rd_data(hist_height), .rd_valid(hist_valid), .rd_ready(hist_ready)
  );

  pha_histogram #(.BIN_BITS(BIN_BITS)) u_hist (
    .aclk, .aresetn,
    .hist_height, .hist_valid, .hist_ready,
    .clear_start, .clear_busy,
    .bin_rd_addr, .bin_rd_en, .bin_rd_data, .bin_rd_done
  );

endmodule

//--- verif/pha_tb.sv
`timescale 1ns/1ns

module pha_tb;

  localparam int BINS        = 256;
  localparam int MAX_SAMPLES = 12000;
  localparam int CLEAR_TIME  = 4 * BINS;
  localparam time TIMEOUT    = (MAX_SAMPLES * 4 + CLEAR_TIME) * 20;

  logic                                  aclk;
  logic                                  aresetn;
  logic [pha_regs_pkg::ADDR_W-1:0]       paddr;
  logic                                  psel;
  logic                                  penable;
  logic                                  pwrite;
  logic [pha_regs_pkg::DATA_W-1:0]       pwdata;
  logic [pha_regs_pkg::DATA_W-1:0]       prdata;
  logic                                  pready;
  logic                                  pslverr;
  pha_data_pkg::sample_t                 sample_data;
  logic                                  sample_valid;
  logic                                  sample_ready;

  int unsigned lcg_state = 48;
  int          errors;
  int          checks;
  int          tests;
  int          test_err_base;
  int unsigned exp_bins [BINS];
  int unsigned pending_q[$];
  int          stall_cnt;

  // software copy of the configuration.
  int unsigned m_holdoff;
  int unsigned m_min_cut;
  int unsigned m_max_cut;
  int unsigned m_baseline;
  bit          m_fixed;

  // detector model state.
  int unsigned m_last;
  int unsigned m_prev;
  int unsigned m_min;
  int unsigned m_hcnt;
  bit          m_rising;
  bit          m_armed;

  pha_top #(.BIN_BITS(8), .FIFO_DEPTH(8)) u_dut (
    .aclk, .aresetn,
    .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .sample_data, .sample_valid, .sample_ready
  );

  always #10 aclk = ~aclk;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
    return lo + (lcg_next() % (hi - lo + 1));
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string name);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == test_err_base) ? "ok" : "errors");
    test_err_base = errors;
  endtask

  // one apb transfer, entered and left at posedge + 2.
  task automatic apb_xfer(input bit wr, input int unsigned addr, input int unsigned wdata,
                          output int unsigned rdata, output bit err);
    paddr   = addr[pha_regs_pkg::ADDR_W-1:0];
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    @(posedge aclk);
    #2;
    penable = 1'b1;
    @(negedge aclk);
    while (!pready)
      @(negedge aclk);
    rdata = prdata;
    err   = pslverr;
    @(posedge aclk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input int unsigned addr, input int unsigned wdata);
    int unsigned rd;
    bit          err;
    apb_xfer(1'b1, addr, wdata, rd, err);
    check_value(err, 1'b0, "pslverr");
  endtask

  task automatic apb_read(input int unsigned addr, output int unsigned rdata);
    bit err;
    apb_xfer(1'b0, addr, 0, rdata, err);
    check_value(err, 1'b0, "pslverr");
  endtask

  task automatic set_cfg(input int unsigned hold, input int unsigned min_cut,
                         input int unsigned max_cut, input int unsigned base, input bit fixed);
    m_holdoff  = hold;
    m_min_cut  = min_cut;
    m_max_cut  = max_cut;
    m_baseline = base;
    m_fixed    = fixed;
    apb_write(pha_regs_pkg::REG_HOLDOFF, hold);
    apb_write(pha_regs_pkg::REG_MIN_CUT, min_cut);
    apb_write(pha_regs_pkg::REG_MAX_CUT, max_cut);
    apb_write(pha_regs_pkg::REG_BASELINE, base);
    apb_write(pha_regs_pkg::REG_CTRL, fixed);
  endtask

  // detector rules applied to one accepted sample.
  task automatic model_sample(input int unsigned s);
    bit          rise_now;
    bit          in_hold;
    bit          min_hit;
    bit          peak_hit;
    int unsigned base;
    int unsigned height;
    rise_now = m_prev < s;
    in_hold  = m_hcnt < m_holdoff;
    min_hit  = !in_hold && !m_rising && rise_now;
    peak_hit = m_armed && m_rising && !rise_now;
    base     = m_fixed ? m_baseline : m_min;
    height   = (m_last - base) & 16'hffff;
    if (peak_hit && height > m_min_cut && m_last < m_max_cut)
      pending_q.push_back(height);
    if (peak_hit)
      m_hcnt = 0;
    else if (in_hold)
      m_hcnt++;
    if (min_hit)
      m_min = m_prev;
    if (peak_hit)
      m_armed = 0;
    else if (min_hit)
      m_armed = 1;
    m_prev   = m_last;
    m_last   = s;
    m_rising = rise_now;
  endtask

  task automatic send_sample(input int unsigned s);
    if (rand_range(0, 3) == 0)
    begin
      sample_valid = 1'b0;
      @(posedge aclk);
      #2;
    end
    sample_data  = s[15:0];
    sample_valid = 1'b1;
    @(negedge aclk);
    while (!sample_ready)
      @(negedge aclk);
    model_sample(s);
    @(posedge aclk);
    #2;
    sample_valid = 1'b0;
  endtask

  task automatic send_pulse(input int unsigned base, input int unsigned amp,
                            input int unsigned width);
    for (int i = 1; i <= width; i++)
      send_sample(base + amp * i / width);
    for (int i = width - 1; i >= 0; i--)
      send_sample(base + amp * i / width);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((pending_q.size() != 0 || !u_dut.hist_ready) && n < 500)
    begin
      @(posedge aclk);
      #2;
      n++;
    end
    if (n >= 500)
    begin
      errors++;
      $display("event path did not drain, %0d events still expected", pending_q.size());
    end
  endtask

  task automatic compare_bins();
    int unsigned d;
    for (int k = 0; k < BINS; k++)
    begin
      apb_read(pha_regs_pkg::BIN_BASE + 4 * k, d);
      check_value(d, exp_bins[k], $sformatf("bin[%0d]", k));
    end
  endtask

  task automatic run_clear();
    int unsigned st;
    int          n;
    apb_write(pha_regs_pkg::REG_CTRL, m_fixed | 2);
    st = 1;
    n  = 0;
    while (st[0] && n < 1000)
    begin
      apb_read(pha_regs_pkg::REG_STATUS, st);
      n++;
    end
    if (st[0])
    begin
      errors++;
      $display("clear_busy never dropped after a clear");
    end
  endtask

  // histogram acceptance moves an expected event into the bin model.
  always @(negedge aclk)
  begin
    if (u_dut.clear_busy)
      foreach (exp_bins[k])
        exp_bins[k] = 0;
    if (sample_valid && !sample_ready)
      stall_cnt++;
    if (u_dut.hist_valid && u_dut.hist_ready)
    begin
      if (pending_q.size() == 0)
      begin
        errors++;
        $display("histogram accepted an event the model did not produce at %0t", $time);
      end
      else
      begin
        check_value(u_dut.hist_height, pending_q[0], "hist_height");
        exp_bins[pending_q[0] >> 8]++;
        void'(pending_q.pop_front());
      end
    end
  end

  initial
  begin
    #(TIMEOUT);
    $display("watchdog expired, the simulation hung");
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    int unsigned rd;
    int unsigned stall_before;
    bit          err;
    aclk          = 0;
    aresetn       = 0;
    paddr         = '0;
    psel          = 0;
    penable       = 0;
    pwrite        = 0;
    pwdata        = '0;
    sample_data   = '0;
    sample_valid  = 0;
    m_last        = 0;
    m_prev        = 0;
    m_min         = 0;
    m_hcnt        = 0;
    m_rising      = 0;
    m_armed       = 0;
    m_holdoff     = 0;
    m_min_cut     = 0;
    m_max_cut     = 0;
    m_baseline    = 0;
    m_fixed       = 0;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    test_err_base = 0;
    stall_cnt     = 0;
    foreach (exp_bins[k])
      exp_bins[k] = 0;
    repeat (2) @(posedge aclk);
    #2;
    aresetn = 1;
    @(posedge aclk);
    #2;

    set_cfg(16'h1234, 16'h0bcd, 16'hfedc, 16'h0321, 1);
    apb_read(pha_regs_pkg::REG_HOLDOFF, rd);
    check_value(rd, 32'h1234, "cfg_holdoff");
    apb_read(pha_regs_pkg::REG_MIN_CUT, rd);
    check_value(rd, 32'h0bcd, "cfg_min_cut");
    apb_read(pha_regs_pkg::REG_MAX_CUT, rd);
    check_value(rd, 32'hfedc, "cfg_max_cut");
    apb_read(pha_regs_pkg::REG_BASELINE, rd);
    check_value(rd, 32'h0321, "cfg_baseline");
    apb_read(pha_regs_pkg::REG_CTRL, rd);
    check_value(rd, 32'h1, "cfg_fixed");
    apb_xfer(1'b0, 12'h020, 0, rd, err);
    check_value(err, 1'b1, "pslverr unmapped");
    end_test("register readback");

    set_cfg(0, 0, 16'hffff, 0, 0);
    repeat (6) send_sample(1000);
    wait_drain();
    run_clear();
    compare_bins();
    end_test("clear");

    // peak 5000 over a minimum of 1000 lands in bin 4000 >> 8.
    repeat (3) send_sample(1000);
    send_pulse(1000, 4000, 8);
    wait_drain();
    apb_read(pha_regs_pkg::BIN_BASE + 4 * 15, rd);
    check_value(rd, 32'd1, "bin[15] increment");
    compare_bins();
    end_test("single pulse");

    set_cfg(0, 2000, 6000, 0, 0);
    repeat (3) send_sample(1000);
    send_pulse(1000, 1500, 5);
    send_pulse(1000, 2000, 4);
    send_pulse(1000, 5000, 6);
    repeat (3) send_sample(1000);
    wait_drain();
    compare_bins();
    end_test("cuts");

    set_cfg(3, 100, 60000, 400, 1);
    for (int p = 0; p < 400; p++)
    begin
      repeat (rand_range(1, 3)) send_sample(500);
      send_pulse(500, rand_range(200, 50000), rand_range(2, 8));
      if (p % 50 == 49)
        apb_read(pha_regs_pkg::BIN_BASE + 4 * rand_range(0, BINS - 1), rd);
    end
    send_sample(500);
    wait_drain();
    compare_bins();
    end_test("random fixed baseline");

    set_cfg(0, 0, 16'hffff, 0, 0);
    stall_before = stall_cnt;
    fork
      begin
        for (int p = 0; p < 150; p++)
        begin
          repeat (rand_range(1, 2)) send_sample(300);
          send_pulse(300, rand_range(500, 60000), rand_range(2, 5));
        end
        send_sample(300);
      end
      begin
        repeat (300) @(posedge aclk);
        #2;
        run_clear();
      end
    join
    wait_drain();
    check_value(stall_cnt > stall_before, 1'b1, "sample_ready stall");
    compare_bins();
    end_test("clear during stream");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- filelist.f
common/pha_regs_pkg.sv
common/pha_data_pkg.sv
analyzer/pha_peak_detector.sv
src/pha_event_fifo.sv
histogram/pha_histogram.sv
src/pha_apb_regs.sv
src/pha_top.sv
verif/pha_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert
TOP        ?= pha_tb
RTL_TOP    ?= pha_top
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
PASS_STR   := \*\*\* PASSED \*\*\*

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)
